/* Makefile */
# Verilator build for the peripheral interconnect testbench

VERILATOR ?= verilator
TOP       ?= tb_periph_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SIM_EXE = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# pass only when the simulation output holds the pass line
run: compile
	@out=$$(./$(SIM_EXE)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(BUILD_DIR)

/* bus_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_decoder (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                req,
  input  logic                                write,
  input  logic [soc_bus_pkg::addr_width-1:0] addr,
  input  logic [soc_bus_pkg::data_width-1:0] wdata,
  input  logic [soc_bus_pkg::mask_width-1:0] rd_mask,
  input  logic [soc_bus_pkg::mask_width-1:0] wr_mask,
  output logic                                ack,
  output logic [soc_bus_pkg::data_width-1:0] rdata,
  soc_bus_if.host                             ram,
  soc_bus_if.host                             led,
  soc_bus_if.host                             key
);
  import soc_bus_pkg::*;

  logic [addr_width-1:0] ram_offset;
  logic [addr_width-1:0] led_offset;
  logic [addr_width-1:0] key_offset;
  logic                  ram_hit;
  logic                  led_hit;
  logic                  key_hit;
  logic                  null_ack;
  logic [mask_width-1:0] rd_mask_q;
  logic [data_width-1:0] sel_data;

  // ==========================================================================
  // window match and request routing
  // ==========================================================================

  // one unsigned compare on the offset covers both window bounds
  assign ram_offset = addr - ram_base;
  assign led_offset = addr - led_base;
  assign key_offset = addr - key_base;

  assign ram_hit = (ram_offset <= (ram_last - ram_base));
  assign led_hit = (led_offset <= (led_last - led_base));
  assign key_hit = (key_offset <= (key_last - key_base));

  assign ram.req     = req & ram_hit;
  assign ram.write   = write;
  assign ram.addr    = ram_offset;
  assign ram.wdata   = wdata;
  assign ram.wr_mask = wr_mask;

  assign led.req     = req & led_hit;
  assign led.write   = write;
  assign led.addr    = led_offset;
  assign led.wdata   = wdata;
  assign led.wr_mask = wr_mask;

  assign key.req     = req & key_hit;
  assign key.write   = write;
  assign key.addr    = key_offset;
  assign key.wdata   = wdata;
  assign key.wr_mask = wr_mask;

  // ==========================================================================
  // null responder
  // ==========================================================================

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      null_ack <= 1'b0;
    end
    else
    begin
      null_ack <= req & ~(ram_hit | led_hit | key_hit);  // unmapped, answer anyway
    end
  end

  // read mask belongs to the request, applied when its ack returns
  always_ff @(posedge clk)
  begin
    if (req)
    begin
      rd_mask_q <= rd_mask;
    end
  end

  // ==========================================================================
  // acknowledge and data return
  // ==========================================================================

  assign ack = ram.ack | led.ack | key.ack | null_ack;

  always_comb
  begin
    sel_data = '0;                   // null responder returns zero
    if (ram.ack)
    begin
      sel_data = ram.rdata;
    end
    else if (led.ack)
    begin
      sel_data = led.rdata;
    end
    else if (key.ack)
    begin
      sel_data = key.rdata;
    end
  end

  always_comb
  begin
    for (int i = 0; i < mask_width; i++)
    begin
      rdata[lane_width*i +: lane_width] = rd_mask_q[i] ? sel_data[lane_width*i +: lane_width]
                                                       : '0;
    end
  end

endmodule

`default_nettype wire

/* key_port.sv */
`timescale 1ns/100ps
`default_nettype none

module key_port (
  input  logic                               clk,
  input  logic                               rst,
  soc_bus_if.target                          bus,
  input  logic [soc_bus_pkg::key_width-1:0] keys
);
  import soc_bus_pkg::*;

  logic [key_width-1:0]  sync_1;
  logic [key_width-1:0]  level;      // second sync stage
  logic [key_width-1:0]  level_prev;
  logic [key_width-1:0]  rise;
  logic [key_width-1:0]  clr;
  logic [key_width-1:0]  press;
  logic                  ack_q;
  logic [data_width-1:0] rdata_q;

  assign rise = level & ~level_prev;
  assign clr  = (bus.req && bus.write && bus.addr == key_press_offset) ?
                bus.wdata[key_width-1:0] : '0;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sync_1     <= '0;
      level      <= '0;
      level_prev <= '0;
      press      <= '0;
      ack_q      <= 1'b0;
    end
    else
    begin
      sync_1     <= keys;
      level      <= sync_1;
      level_prev <= level;
      press      <= (press & ~clr) | rise;  // new edge beats the clear
      ack_q      <= bus.req;
    end
  end

  always_ff @(posedge clk)
  begin
    rdata_q <= '0;
    if (bus.req && !bus.write)
    begin
      if (bus.addr == key_level_offset)
        rdata_q <= {{(data_width-key_width){1'b0}}, level};
      else if (bus.addr == key_press_offset)
        rdata_q <= {{(data_width-key_width){1'b0}}, press};
    end
  end

  assign bus.ack   = ack_q;
  assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

/* led_port.sv */
`timescale 1ns/100ps
`default_nettype none

module led_port (
  input  logic                               clk,
  input  logic                               rst,
  soc_bus_if.target                          bus,
  output logic [soc_bus_pkg::led_width-1:0] leds
);
  import soc_bus_pkg::*;

  logic [data_width-1:0] led_q;
  logic                  ack_q;
  logic [data_width-1:0] rdata_q;

  // output register, any offset in the window maps here
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      led_q <= '0;
    end
    else if (bus.req && bus.write)
    begin
      for (int i = 0; i < mask_width; i++)
      begin
        if (bus.wr_mask[i])
        begin
          led_q[lane_width*i +: lane_width] <= bus.wdata[lane_width*i +: lane_width];
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ack_q <= 1'b0;
    end
    else
    begin
      ack_q <= bus.req;
    end
    rdata_q <= (bus.req && !bus.write) ? led_q : '0;  // full readback
  end

  assign bus.ack   = ack_q;
  assign bus.rdata = rdata_q;
  assign leds      = led_q[led_width-1:0];

endmodule

`default_nettype wire

/* periph_top.sv */
`timescale 1ns/100ps
`default_nettype none

module periph_top (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                req,
  input  logic                                write,
  input  logic [soc_bus_pkg::addr_width-1:0] addr,
  input  logic [soc_bus_pkg::data_width-1:0] wdata,
  input  logic [soc_bus_pkg::mask_width-1:0] rd_mask,
  input  logic [soc_bus_pkg::mask_width-1:0] wr_mask,
  input  logic [soc_bus_pkg::key_width-1:0]  keys,
  output logic                                ack,
  output logic [soc_bus_pkg::data_width-1:0] rdata,
  output logic [soc_bus_pkg::led_width-1:0]  leds
);

  // one channel per target
  soc_bus_if bus_ram ();
  soc_bus_if bus_led ();
  soc_bus_if bus_key ();

  bus_decoder u_bus_decoder (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .write   (write),
    .addr    (addr),
    .wdata   (wdata),
    .rd_mask (rd_mask),
    .wr_mask (wr_mask),
    .ack     (ack),
    .rdata   (rdata),
    .ram     (bus_ram.host),
    .led     (bus_led.host),
    .key     (bus_key.host)
  );

  word_ram u_word_ram (
    .clk (clk),
    .bus (bus_ram.target)
  );

  led_port u_led_port (
    .clk  (clk),
    .rst  (rst),
    .bus  (bus_led.target),
    .leds (leds)
  );

  key_port u_key_port (
    .clk  (clk),
    .rst  (rst),
    .bus  (bus_key.target),
    .keys (keys)
  );

endmodule

`default_nettype wire

/* soc_bus_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface soc_bus_if;
  import soc_bus_pkg::*;

  logic                  req;        // one-cycle strobe
  logic                  write;
  logic [addr_width-1:0] addr;       // offset inside the window
  logic [data_width-1:0] wdata;
  logic [mask_width-1:0] wr_mask;

  logic                  ack;        // exactly one cycle after req
  logic [data_width-1:0] rdata;      // zero while ack is low

  modport host (
    output req,
    output write,
    output addr,
    output wdata,
    output wr_mask,
    input  ack,
    input  rdata
  );

  modport target (
    input  req,
    input  write,
    input  addr,
    input  wdata,
    input  wr_mask,
    output ack,
    output rdata
  );

endinterface

`default_nettype wire

/* soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

  // ==========================================================================
  // bus widths
  // ==========================================================================

  localparam int unsigned addr_width = 32;
  localparam int unsigned data_width = 32;
  localparam int unsigned mask_width = 4;              // byte lanes per word
  localparam int unsigned lane_width = data_width / mask_width;
  localparam int unsigned byte_addr_bits = $clog2(mask_width);

  localparam int unsigned target_count = 3;

  // channel index of each target
  localparam int unsigned target_ram = 0;
  localparam int unsigned target_led = 1;
  localparam int unsigned target_key = 2;

  // ==========================================================================
  // memory map
  // ==========================================================================

  localparam logic [addr_width-1:0] ram_base = 32'h0000_0000;
  localparam logic [addr_width-1:0] ram_last = 32'h0000_0FFF;
  localparam int unsigned ram_words = 1024;
  localparam int unsigned ram_index_width = $clog2(ram_words);

  localparam logic [addr_width-1:0] led_base = 32'hC000_0000;
  localparam logic [addr_width-1:0] led_last = 32'hC000_FFFF;

  localparam logic [addr_width-1:0] key_base = 32'hC100_0000;
  localparam logic [addr_width-1:0] key_last = 32'hC100_FFFF;

  // ==========================================================================
  // target registers
  // ==========================================================================

  localparam int unsigned led_width = 8;
  localparam int unsigned key_width = 8;

  localparam logic [addr_width-1:0] key_level_offset = 32'h0000_0000;  // synced level
  localparam logic [addr_width-1:0] key_press_offset = 32'h0000_0004;  // press latch, w1c

endpackage

`default_nettype wire

/* tb_periph_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_periph_top;
  import soc_bus_pkg::*;

  typedef struct packed {
    logic                  settle;     // apply keys and idle four cycles
    logic                  write;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] wdata;
    logic [mask_width-1:0] rd_mask;
    logic [mask_width-1:0] wr_mask;
    logic [key_width-1:0]  keys;
    logic [data_width-1:0] exp_rdata;
    logic [led_width-1:0]  exp_leds;
  } entry_t;

  logic                  clk;
  logic                  rst;
  logic                  req;
  logic                  write;
  logic [addr_width-1:0] addr;
  logic [data_width-1:0] wdata;
  logic [mask_width-1:0] rd_mask;
  logic [mask_width-1:0] wr_mask;
  logic [key_width-1:0]  keys;
  logic                  ack;
  logic [data_width-1:0] rdata;
  logic [led_width-1:0]  leds;

  entry_t                table_q[$];
  logic [data_width-1:0] model [ram_words];
  logic [31:0]           rnd;
  logic                  req_q;

  periph_top u_periph_top (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .write   (write),
    .addr    (addr),
    .wdata   (wdata),
    .rd_mask (rd_mask),
    .wr_mask (wr_mask),
    .keys    (keys),
    .ack     (ack),
    .rdata   (rdata),
    .leds    (leds)
  );

  always #20 clk = ~clk;

  // ==========================================================================
  // helpers
  // ==========================================================================

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] idx);
    return (idx * 32'h9E37_79B1) ^ 32'hA5A5_0000 ^ idx;  // whole index mixed in
  endfunction

  function automatic logic [31:0] keep_lanes(input logic [31:0] d, input logic [3:0] m);
    logic [31:0] r;
    for (int i = 0; i < 4; i++)
    begin
      r[8*i +: 8] = m[i] ? d[8*i +: 8] : 8'h00;
    end
    return r;
  endfunction

  function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] d,
                                              input logic [3:0] m);
    return keep_lanes(d, m) | keep_lanes(old, ~m);
  endfunction

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp)
    else
    begin
      $display("[FAIL] time %0t: %s expected %h got %h", $time, name, exp, got);
      abort_run();
    end
  endtask

  task automatic wait_for_ack(input string what);
    int waited;
    waited = 0;
    while (ack !== 1'b1)
    begin
      if (waited >= 10)
      begin
        $display("timeout: no acknowledge for %s within 10 cycles", what);
        abort_run();
      end
      @(posedge clk);
      #2;
      waited++;
    end
  endtask

  // single request driven 2 ns after a rising edge
  task automatic issue(input logic wr, input logic [31:0] a, input logic [31:0] d,
                       input logic [3:0] rm, input logic [3:0] wm, output logic [31:0] got);
    req     = 1'b1;
    write   = wr;
    addr    = a;
    wdata   = d;
    rd_mask = rm;
    wr_mask = wm;
    @(posedge clk);
    #2;
    req = 1'b0;
    wait_for_ack(wr ? "write request" : "read request");
    got = rdata;
  endtask

  task automatic add_entry(input logic s, input logic w, input logic [31:0] a,
                           input logic [31:0] d, input logic [3:0] rm, input logic [3:0] wm,
                           input logic [7:0] k, input logic [31:0] er, input logic [7:0] el);
    table_q.push_back({s, w, a, d, rm, wm, k, er, el});
  endtask

  // write then read of one random word on consecutive cycles
  task automatic random_pair();
    logic [31:0] a;
    logic [31:0] d;
    logic [3:0]  wm;
    logic [3:0]  rm;
    logic [31:0] got;
    rnd = xorshift(rnd);
    a   = {20'b0, rnd[11:0]};
    rnd = xorshift(rnd);
    d   = rnd;
    rnd = xorshift(rnd);
    wm  = rnd[3:0];
    rm  = rnd[7:4];
    req = 1'b1;
    write = 1'b1;
    addr  = a;
    wdata = d;
    wr_mask = wm;
    rd_mask = 4'hf;
    model[a[11:2]] = merge_lanes(model[a[11:2]], d, wm);
    @(posedge clk);
    #2;
    check_value("rdata", 32'h0, rdata);  // write ack carries zero
    write   = 1'b0;
    wdata   = '0;
    rd_mask = rm;
    @(posedge clk);
    #2;
    req = 1'b0;
    wait_for_ack("random RAM read");
    got = rdata;
    check_value("rdata", keep_lanes(model[a[11:2]], rm), got);
  endtask

  // ack must follow every req by exactly one cycle
  always @(posedge clk)
  begin
    req_q <= req;
  end

  always @(negedge clk)
  begin
    assert (ack === req_q)
    else
    begin
      $display("[FAIL] time %0t: ack expected %b got %b", $time, req_q, ack);
      abort_run();
    end
  end

  // ==========================================================================
  // main sequence
  // ==========================================================================

  initial
  begin
    entry_t      e;
    logic [31:0] got;
    clk = 1'b0;
    rst = 1'b1;
    req = 1'b0;
    write = 1'b0;
    addr = '0;
    wdata = '0;
    rd_mask = '0;
    wr_mask = '0;
    keys = '0;
    rnd = 32'h26f9469c;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    check_value("leds", 32'h0, 32'(leds));

    // back-to-back full-mask fill of the whole RAM
    for (int i = 0; i < ram_words; i++)
    begin
      req = 1'b1;
      write = 1'b1;
      addr = 32'(i * 4);
      wdata = fill_word(32'(i));
      wr_mask = 4'hf;
      model[i] = fill_word(32'(i));
      @(posedge clk);
      #2;
    end
    req = 1'b0;
    @(posedge clk);
    #2;

    add_entry(0, 1, 32'h0000_0010, 32'h1122_3344, 4'hf, 4'hf, 8'h00, 32'h0, 8'h00);
    add_entry(0, 1, 32'h0000_0010, 32'hAABB_CCDD, 4'hf, 4'h5, 8'h00, 32'h0, 8'h00);
    add_entry(0, 0, 32'h0000_0010, 32'h0, 4'hf, 4'h0, 8'h00, 32'h11BB_33DD, 8'h00);
    add_entry(0, 0, 32'h0000_0010, 32'h0, 4'h3, 4'h0, 8'h00, 32'h0000_33DD, 8'h00);
    add_entry(0, 0, 32'h0000_0010, 32'h0, 4'h8, 4'h0, 8'h00, 32'h1100_0000, 8'h00);
    add_entry(0, 0, 32'hC000_0000, 32'h0, 4'hf, 4'h0, 8'h00, 32'h0, 8'h00);
    add_entry(0, 1, 32'hC000_0000, 32'h1234_5678, 4'hf, 4'hf, 8'h00, 32'h0, 8'h78);
    add_entry(0, 0, 32'hC000_0000, 32'h0, 4'hf, 4'h0, 8'h00, 32'h1234_5678, 8'h78);
    add_entry(0, 1, 32'hC000_0010, 32'hFFFF_FFA5, 4'hf, 4'h1, 8'h00, 32'h0, 8'hA5);
    add_entry(0, 0, 32'hC000_FFFC, 32'h0, 4'hc, 4'h0, 8'h00, 32'h1234_0000, 8'hA5);
    add_entry(1, 0, 32'hC100_0000, 32'h0, 4'hf, 4'h0, 8'h05, 32'h0000_0005, 8'hA5);
    add_entry(0, 0, 32'hC100_0004, 32'h0, 4'hf, 4'h0, 8'h05, 32'h0000_0005, 8'hA5);
    add_entry(0, 1, 32'hC100_0004, 32'h1, 4'hf, 4'hf, 8'h05, 32'h0, 8'hA5);
    add_entry(0, 0, 32'hC100_0004, 32'h0, 4'hf, 4'h0, 8'h05, 32'h0000_0004, 8'hA5);
    add_entry(1, 0, 32'hC100_0004, 32'h0, 4'hf, 4'h0, 8'h0D, 32'h0000_000C, 8'hA5);
    add_entry(0, 0, 32'hC100_0000, 32'h0, 4'h1, 4'h0, 8'h0D, 32'h0000_000D, 8'hA5);
    add_entry(0, 0, 32'hC100_0000, 32'h0, 4'h0, 4'h0, 8'h0D, 32'h0, 8'hA5);
    // unmapped windows
    add_entry(0, 0, 32'h0000_1000, 32'h0, 4'hf, 4'h0, 8'h0D, 32'h0, 8'hA5);
    add_entry(0, 1, 32'h0000_1000, 32'hDEAD_BEEF, 4'hf, 4'hf, 8'h0D, 32'h0, 8'hA5);
    add_entry(0, 0, 32'h0000_0000, 32'h0, 4'hf, 4'h0, 8'h0D, fill_word(32'h0), 8'hA5);
    add_entry(0, 1, 32'hC001_0000, 32'h0, 4'hf, 4'hf, 8'h0D, 32'h0, 8'hA5);
    add_entry(0, 1, 32'h8000_0000, 32'hFFFF_FFFF, 4'hf, 4'hf, 8'h0D, 32'h0, 8'hA5);
    add_entry(0, 1, 32'hC101_0004, 32'hFFFF_FFFF, 4'hf, 4'hf, 8'h0D, 32'h0, 8'hA5);
    add_entry(0, 0, 32'hC000_0000, 32'h0, 4'hf, 4'h0, 8'h0D, 32'h1234_56A5, 8'hA5);
    add_entry(0, 0, 32'hC100_0004, 32'h0, 4'hf, 4'h0, 8'h0D, 32'h0000_000C, 8'hA5);
    add_entry(0, 0, 32'hC100_0000, 32'h0, 4'hf, 4'h0, 8'h0D, 32'h0000_000D, 8'hA5);
    add_entry(0, 0, 32'hC200_0000, 32'h0, 4'hf, 4'h0, 8'h0D, 32'h0, 8'hA5);

    foreach (table_q[n])
    begin
      e = table_q[n];
      keys = e.keys;
      if (e.settle)
      begin
        repeat (4) @(posedge clk);  // sync stages plus edge detect
        #2;
      end
      issue(e.write, e.addr, e.wdata, e.rd_mask, e.wr_mask, got);
      check_value("rdata", e.exp_rdata, got);
      check_value("leds", 32'(e.exp_leds), 32'(leds));
      if (e.write && e.addr <= ram_last)
      begin
        model[e.addr[11:2]] = merge_lanes(model[e.addr[11:2]], e.wdata, e.wr_mask);
      end
    end

    for (int i = 0; i < 200; i++)
    begin
      random_pair();
    end

    @(posedge clk);
    #2;
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
soc_bus_pkg.sv
soc_bus_if.sv
bus_decoder.sv
word_ram.sv
led_port.sv
key_port.sv
periph_top.sv
tb_periph_top.sv

/* word_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module word_ram (
  input  logic       clk,
  soc_bus_if.target  bus
);
  import soc_bus_pkg::*;

  logic [data_width-1:0]      mem [ram_words];
  logic [ram_index_width-1:0] index;
  logic                       ack_q;
  logic [data_width-1:0]      rdata_q;

  assign index = bus.addr[byte_addr_bits +: ram_index_width];  // word index, lanes dropped

  // byte lane writes
  always_ff @(posedge clk)
  begin
    if (bus.req && bus.write)
    begin
      for (int i = 0; i < mask_width; i++)
      begin
        if (bus.wr_mask[i])
        begin
          mem[index][lane_width*i +: lane_width] <= bus.wdata[lane_width*i +: lane_width];
        end
      end
    end
  end

  // registered read, every request answered next cycle
  always_ff @(posedge clk)
  begin
    ack_q <= bus.req;
    if (bus.req && !bus.write)
    begin
      rdata_q <= mem[index];
    end
    else
    begin
      rdata_q <= '0;                 // writes and idle cycles return zero
    end
  end

  assign bus.ack   = ack_q;
  assign bus.rdata = rdata_q;

endmodule

`default_nettype wire
